/* common/capture_params.svh */
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// sample and word widths
`define SAMPLE_W        16
`define IQ_W            32
`define CAP_W           64

// simulated adc path length in sample clocks
`define LOOPBACK_DELAY  100

// latency window per dds source
`define DELAY_CHIRP     3
`define DELAY_WFRM      19
`define LAT_CNT_W       8

// control word field positions
`define ROUTE_L_LSB     0
`define ROUTE_U_LSB     4
`define SRC_LSB         8

`endif

/* common/capture_pkg.sv */
`include "capture_params.svh"

package capture_pkg;

  // one signed converter sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // i in upper half, q in lower half
  typedef logic [`IQ_W-1:0] iq_t;

  // sample count, global count, stamp fields
  typedef logic [31:0] count_t;

  // upper half then lower half
  typedef logic [`CAP_W-1:0] cap_word_t;

  typedef logic [31:0] ctrl_word_t;

  // source select for one half of the capture word
  typedef enum logic [1:0] {
    ROUTE_ADC        = 2'd0,
    ROUTE_DAC        = 2'd1,
    ROUTE_SAMPLE_CNT = 2'd2,
    ROUTE_GLOBAL_CNT = 2'd3
  } route_e;

endpackage

/* rtl/ctrl_word_decode.sv */
`timescale 1ns/1ps

`include "capture_params.svh"

module ctrl_word_decode
  import capture_pkg::*;
(
  input  logic       clk_245_76MHz,
  input  logic       cpu_reset,
  input  ctrl_word_t chirp_control_word_i,
  output route_e     route_lower_o,
  output route_e     route_upper_o,
  output logic       wfrm_src_sel_o
);

  // raw two-bit fields straight from the control word
  logic [1:0] route_l_field;
  logic [1:0] route_u_field;
  logic [1:0] src_field;

  assign route_l_field = chirp_control_word_i[`ROUTE_L_LSB +: 2];
  assign route_u_field = chirp_control_word_i[`ROUTE_U_LSB +: 2];
  assign src_field     = chirp_control_word_i[`SRC_LSB +: 2];

  // one register stage, same as the capture path sees it
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_lower_o  <= ROUTE_ADC;
      route_upper_o  <= ROUTE_ADC;
      wfrm_src_sel_o <= 1'b0;
    end else begin
      route_lower_o  <= route_e'(route_l_field);
      route_upper_o  <= route_e'(route_u_field);
      // waveform source only when both source bits set
      wfrm_src_sel_o <= &src_field;
    end
  end

  // decoded selects feed the word mux and the window length
  assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !$isunknown({route_lower_o, route_upper_o, wfrm_src_sel_o}))
    else $error("ctrl_word_decode: X on decoded selects");

endmodule

/* rtl/dac_adc_loopback.sv */
`timescale 1ns/1ps

`include "capture_params.svh"

module dac_adc_loopback
  import capture_pkg::*;
(
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  iq_t  dds_iq_i,
  output iq_t  dac_iq_o,
  output iq_t  adc_iq_o
);

  // dac side register, stands in for the converter board input stage
  iq_t dac_iq_q;

  // split halves for the per-sample shift
  sample_t dac_i;
  sample_t dac_q;
  iq_t     half_iq;

  // adc delay line, stage 0 is newest
  iq_t delay_q [`LOOPBACK_DELAY];

  always_ff @(posedge clk_245_76MHz) begin
    dac_iq_q <= dds_iq_i;
  end

  assign dac_i = dac_iq_q[`IQ_W-1 -: `SAMPLE_W];
  assign dac_q = dac_iq_q[`SAMPLE_W-1:0];

  // halve each sample, keep the sign
  assign half_iq = {dac_i >>> 1, dac_q >>> 1};

  // line reads zero until the first sample comes through
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int s = 0; s < `LOOPBACK_DELAY; s++) begin
        delay_q[s] <= '0;
      end
    end else begin
      delay_q[0] <= half_iq;
      for (int s = 1; s < `LOOPBACK_DELAY; s++) begin
        delay_q[s] <= delay_q[s-1];
      end
    end
  end

  assign dac_iq_o = dac_iq_q;
  // last stage holds the halved dac sample from LOOPBACK_DELAY clocks back
  assign adc_iq_o = delay_q[`LOOPBACK_DELAY-1];

endmodule

/* capture/capture_sequencer.sv */
`timescale 1ns/1ps

`include "capture_params.svh"

module capture_sequencer
  import capture_pkg::*;
(
  input  logic   clk_245_76MHz,
  input  logic   cpu_reset,
  input  logic   adc_enable_i,
  input  logic   chirp_init_i,
  input  logic   wfrm_src_sel_i,
  output logic   cap_valid_o,
  output logic   cap_first_o,
  output logic   cap_last_o,
  output count_t sample_cnt_o,
  output count_t global_cnt_o
);

  // enable pipeline
  logic enable_r;
  logic enable_rr;

  // latency window
  logic [`LAT_CNT_W-1:0] lat_cnt;
  logic [`LAT_CNT_W-1:0] lat_load;
  logic                  lat_zero;
  logic                  enable_fall;

  logic   first_q;
  count_t sample_cnt;
  count_t global_cnt;

  // window length depends on which dds is feeding the dac
  assign lat_load = wfrm_src_sel_i ? `LAT_CNT_W'(`DELAY_WFRM) : `LAT_CNT_W'(`DELAY_CHIRP);
  assign lat_zero = (lat_cnt == '0);

  // enable_r still high, new sample low
  assign enable_fall = enable_r & ~adc_enable_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r  <= 1'b0;
      enable_rr <= 1'b0;
    end else begin
      enable_r <= adc_enable_i;
      // second stage frozen while the window drains
      if (lat_zero) begin
        enable_rr <= enable_r;
      end
    end
  end

  // reload on chirp start or on enable drop, else count down
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      lat_cnt <= '0;
    end else if (chirp_init_i || enable_fall) begin
      lat_cnt <= lat_load;
    end else if (!lat_zero) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  // frame opens when enable_rr is about to follow enable_r up
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      first_q <= 1'b0;
    end else begin
      first_q <= lat_zero & enable_r & ~enable_rr;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt <= '0;
      global_cnt <= '0;
    end else begin
      global_cnt <= global_cnt + 1'b1;
      // counts words already sent, stamp shows words before it
      if (enable_rr) begin
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  assign cap_valid_o  = enable_rr;
  assign cap_first_o  = first_q;
  // frame closes on the last drained cycle
  assign cap_last_o   = lat_zero & enable_rr & ~enable_r;
  assign sample_cnt_o = sample_cnt;
  assign global_cnt_o = global_cnt;

  // a frame cannot open and close on the same word
  assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(cap_first_o && cap_last_o))
    else $error("capture_sequencer: first and last together");

  // stamps only go out on valid words
  assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    (cap_first_o || cap_last_o) |-> cap_valid_o)
    else $error("capture_sequencer: frame flag without valid");

  assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    lat_cnt <= `LAT_CNT_W'(`DELAY_WFRM))
    else $error("capture_sequencer: latency counter out of range");

endmodule

/* capture/capture_word_builder.sv */
`timescale 1ns/1ps

module capture_word_builder
  import capture_pkg::*;
(
  input  route_e    route_lower_i,
  input  route_e    route_upper_i,
  input  iq_t       adc_iq_i,
  input  iq_t       dac_iq_i,
  input  count_t    sample_cnt_i,
  input  count_t    global_cnt_i,
  input  logic      cap_valid_i,
  input  logic      cap_first_i,
  input  logic      cap_last_i,
  output cap_word_t cap_tdata_o,
  output logic      cap_tvalid_o,
  output logic      cap_tfirst_o,
  output logic      cap_tlast_o
);

  iq_t       half_lower;
  iq_t       half_upper;
  cap_word_t stamp_word;

  // same mux for both halves
  function automatic iq_t route_mux(input route_e sel, input iq_t adc_iq, input iq_t dac_iq,
                                    input count_t s_cnt, input count_t g_cnt);
    iq_t res;
    case (sel)
      ROUTE_ADC:        res = adc_iq;
      ROUTE_DAC:        res = dac_iq;
      ROUTE_SAMPLE_CNT: res = s_cnt;
      ROUTE_GLOBAL_CNT: res = g_cnt;
      default:          res = adc_iq;
    endcase
    return res;
  endfunction

  assign half_lower = route_mux(route_lower_i, adc_iq_i, dac_iq_i, sample_cnt_i, global_cnt_i);
  assign half_upper = route_mux(route_upper_i, adc_iq_i, dac_iq_i, sample_cnt_i, global_cnt_i);

  // stamp: global count on top, sample count below
  assign stamp_word = {global_cnt_i[31:0], sample_cnt_i};

  // frame edges carry the stamp instead of data
  assign cap_tdata_o  = (cap_first_i || cap_last_i) ? stamp_word : {half_upper, half_lower};
  assign cap_tvalid_o = cap_valid_i;
  assign cap_tfirst_o = cap_first_i;
  assign cap_tlast_o  = cap_last_i;

endmodule

/* rtl/chirp_capture_top.sv */
`timescale 1ns/1ps

module chirp_capture_top
  import capture_pkg::*;
(
  input  logic       clk_245_76MHz,
  input  logic       cpu_reset,
  input  iq_t        dds_iq_i,
  input  ctrl_word_t chirp_control_word_i,
  input  logic       adc_enable_i,
  input  logic       chirp_init_i,
  output cap_word_t  cap_tdata_o,
  output logic       cap_tvalid_o,
  output logic       cap_tfirst_o,
  output logic       cap_tlast_o
);

  // decoded control
  route_e route_lower;
  route_e route_upper;
  logic   wfrm_src_sel;

  // converter stand-in
  iq_t dac_iq;
  iq_t adc_iq;

  // framing and counters
  logic   cap_valid;
  logic   cap_first;
  logic   cap_last;
  count_t sample_cnt;
  count_t global_cnt;

  ctrl_word_decode u_decode (
    .clk_245_76MHz        (clk_245_76MHz),
    .cpu_reset            (cpu_reset),
    .chirp_control_word_i (chirp_control_word_i),
    .route_lower_o        (route_lower),
    .route_upper_o        (route_upper),
    .wfrm_src_sel_o       (wfrm_src_sel)
  );

  dac_adc_loopback u_loopback (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .dds_iq_i      (dds_iq_i),
    .dac_iq_o      (dac_iq),
    .adc_iq_o      (adc_iq)
  );

  capture_sequencer u_execute (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .adc_enable_i   (adc_enable_i),
    .chirp_init_i   (chirp_init_i),
    .wfrm_src_sel_i (wfrm_src_sel),
    .cap_valid_o    (cap_valid),
    .cap_first_o    (cap_first),
    .cap_last_o     (cap_last),
    .sample_cnt_o   (sample_cnt),
    .global_cnt_o   (global_cnt)
  );

  // combinational, no added latency on the capture outputs
  capture_word_builder u_result (
    .route_lower_i (route_lower),
    .route_upper_i (route_upper),
    .adc_iq_i      (adc_iq),
    .dac_iq_i      (dac_iq),
    .sample_cnt_i  (sample_cnt),
    .global_cnt_i  (global_cnt),
    .cap_valid_i   (cap_valid),
    .cap_first_i   (cap_first),
    .cap_last_i    (cap_last),
    .cap_tdata_o   (cap_tdata_o),
    .cap_tvalid_o  (cap_tvalid_o),
    .cap_tfirst_o  (cap_tfirst_o),
    .cap_tlast_o   (cap_tlast_o)
  );

endmodule

/* sim/capture_checker.sv */
`timescale 1ns/1ps

`include "capture_params.svh"

module capture_checker
  import capture_pkg::*;
(
  input  logic      clk_245_76MHz,
  input  logic      cpu_reset,
  input  iq_t       dds_iq_i,
  input  logic      adc_enable_i,
  input  logic      chirp_init_i,
  input  cap_word_t cap_tdata_i,
  input  logic      cap_tvalid_i,
  input  logic      cap_tfirst_i,
  input  logic      cap_tlast_i,
  input  route_e    exp_upper_i,
  input  route_e    exp_lower_i,
  input  int        exp_delay_i,
  input  int        test_id_i,
  input  logic      test_end_i,
  output int        pass_cnt_o,
  output int        fail_cnt_o
);

  // reference counters, cycle count mirrors the global counter
  count_t ref_cycle;
  count_t ref_sample;
  count_t init_cycle;
  iq_t    dds_prev;
  int     dds_stable;
  int     post_cnt;
  int     errors;
  int     frames;
  logic   valid_prev;
  logic   idle;
  logic   dropped;
  logic   init_pending;

  // arithmetic shift right per 16-bit half
  function automatic iq_t halve_iq(input iq_t v);
    return {v[31], v[31:17], v[15], v[15:1]};
  endfunction

  task automatic report_value(input string name, input logic [31:0] want, input logic [31:0] got);
    $display("FAILED %s in test %0d: expected 0x%h, got 0x%h", name, test_id_i, want, got);
    errors++;
  endtask

  task automatic check_half(input string name, input route_e sel, input iq_t got);
    iq_t want;
    case (sel)
      ROUTE_ADC: begin
        // adc only meaningful once the delay line holds the constant sample
        if (dds_stable <= `LOOPBACK_DELAY) begin
          $display("test %0d: adc half sampled before the delay line filled", test_id_i);
          errors++;
        end
        want = halve_iq(dds_iq_i);
      end
      ROUTE_DAC:        want = dds_prev;
      ROUTE_SAMPLE_CNT: want = ref_sample;
      default:          want = ref_cycle;
    endcase
    if (got !== want) begin
      report_value(name, want, got);
    end
  endtask

  // mid-cycle sampling, inputs and outputs are settled here
  always @(negedge clk_245_76MHz) begin
    if (dds_iq_i === dds_prev) begin
      dds_stable = dds_stable + 1;
    end else begin
      dds_stable = 0;
    end
    if (cpu_reset) begin
      ref_cycle    = '0;
      ref_sample   = '0;
      valid_prev   = 1'b0;
      idle         = 1'b1;
      dropped      = 1'b0;
      init_pending = 1'b0;
      errors       = 0;
      frames       = 0;
      pass_cnt_o   = 0;
      fail_cnt_o   = 0;
    end else begin
      // nothing may leave the capture side between frames
      if (idle && (cap_tvalid_i || cap_tfirst_i || cap_tlast_i)) begin
        report_value("{cap_tvalid_o,cap_tfirst_o,cap_tlast_o}", 0,
                     {cap_tvalid_i, cap_tfirst_i, cap_tlast_i});
      end
      // first flag exactly on the word where valid rises
      if (cap_tfirst_i != (cap_tvalid_i && !valid_prev)) begin
        report_value("cap_tfirst_o", cap_tvalid_i && !valid_prev, cap_tfirst_i);
      end
      if (cap_tfirst_i && init_pending) begin
        if (int'(ref_cycle - init_cycle) <= exp_delay_i) begin
          $display("test %0d: first word came inside the latency window", test_id_i);
          errors++;
        end
        init_pending = 1'b0;
      end
      // stamp words, then routed data words
      if (cap_tvalid_i && (cap_tfirst_i || cap_tlast_i)) begin
        if (cap_tdata_i[63:32] !== ref_cycle) begin
          report_value("cap_tdata_o[63:32]", ref_cycle, cap_tdata_i[63:32]);
        end
        if (cap_tdata_i[31:0] !== ref_sample) begin
          report_value("cap_tdata_o[31:0]", ref_sample, cap_tdata_i[31:0]);
        end
      end else if (cap_tvalid_i) begin
        check_half("cap_tdata_o[63:32]", exp_upper_i, cap_tdata_i[63:32]);
        check_half("cap_tdata_o[31:0]", exp_lower_i, cap_tdata_i[31:0]);
      end
      // words after the edge that samples enable low
      if (dropped && cap_tvalid_i) begin
        post_cnt++;
        if (cap_tlast_i != (post_cnt == exp_delay_i + 1)) begin
          report_value("cap_tlast_o", post_cnt == exp_delay_i + 1, cap_tlast_i);
        end
      end else if (cap_tlast_i) begin
        report_value("cap_tlast_o", 0, cap_tlast_i);
      end
      if (cap_tlast_i) begin
        frames++;
        idle    = 1'b1;
        dropped = 1'b0;
      end
      if (!idle && !dropped && !adc_enable_i) begin
        dropped  = 1'b1;
        post_cnt = 0;
      end
      if (adc_enable_i) begin
        idle = 1'b0;
      end
      if (chirp_init_i) begin
        init_pending = 1'b1;
        init_cycle   = ref_cycle;
      end
      if (test_end_i) begin
        // idle test closes no frame, every other test exactly one
        if (frames != ((test_id_i == 0) ? 0 : 1)) begin
          $display("test %0d: wrong number of closed frames, saw %0d", test_id_i, frames);
          errors++;
        end
        if (errors == 0) begin
          pass_cnt_o++;
          $display("test %0d: ok", test_id_i);
        end else begin
          fail_cnt_o++;
          $display("test %0d: %0d errors", test_id_i, errors);
        end
        errors = 0;
        frames = 0;
      end
      if (cap_tvalid_i) begin
        ref_sample = ref_sample + 1;
      end
      ref_cycle  = ref_cycle + 1;
      valid_prev = cap_tvalid_i;
    end
    dds_prev = dds_iq_i;
  end

endmodule

/* sim/tb_chirp_capture.sv */
`timescale 1ns/1ps

`include "capture_params.svh"

module tb_chirp_capture
  import capture_pkg::*;
();

  localparam int NUM_ROWS     = 7;
  localparam int LAST_TIMEOUT = 200;

  logic       clk_245_76MHz;
  logic       cpu_reset;
  iq_t        dds_iq;
  ctrl_word_t ctrl_word;
  logic       adc_enable;
  logic       chirp_init;
  cap_word_t  cap_tdata;
  logic       cap_tvalid;
  logic       cap_tfirst;
  logic       cap_tlast;

  // expected values handed to the checker
  route_e exp_upper;
  route_e exp_lower;
  int     exp_delay;
  int     test_id;
  logic   test_end;
  int     pass_cnt;
  int     fail_cnt;
  int     seed;
  int     r;
  logic   timed_out;
  logic   row_rand;

  // stimulus table, one entry per frame test
  ctrl_word_t tab_ctrl [NUM_ROWS];
  logic [1:0] tab_src [NUM_ROWS];
  int         tab_en_len [NUM_ROWS];
  logic       tab_init [NUM_ROWS];
  iq_t        tab_dds [NUM_ROWS];
  logic       tab_dds_rand [NUM_ROWS];
  route_e     tab_upper [NUM_ROWS];
  route_e     tab_lower [NUM_ROWS];

  always #4 clk_245_76MHz = ~clk_245_76MHz;

  chirp_capture_top u_dut (
    .clk_245_76MHz        (clk_245_76MHz),
    .cpu_reset            (cpu_reset),
    .dds_iq_i             (dds_iq),
    .chirp_control_word_i (ctrl_word),
    .adc_enable_i         (adc_enable),
    .chirp_init_i         (chirp_init),
    .cap_tdata_o          (cap_tdata),
    .cap_tvalid_o         (cap_tvalid),
    .cap_tfirst_o         (cap_tfirst),
    .cap_tlast_o          (cap_tlast)
  );

  capture_checker u_checker (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .dds_iq_i      (dds_iq),
    .adc_enable_i  (adc_enable),
    .chirp_init_i  (chirp_init),
    .cap_tdata_i   (cap_tdata),
    .cap_tvalid_i  (cap_tvalid),
    .cap_tfirst_i  (cap_tfirst),
    .cap_tlast_i   (cap_tlast),
    .exp_upper_i   (exp_upper),
    .exp_lower_i   (exp_lower),
    .exp_delay_i   (exp_delay),
    .test_id_i     (test_id),
    .test_end_i    (test_end),
    .pass_cnt_o    (pass_cnt),
    .fail_cnt_o    (fail_cnt)
  );

  task automatic set_row(input int idx, input ctrl_word_t c, input logic [1:0] src,
                         input int len, input logic init, input iq_t dds, input logic rnd,
                         input route_e up, input route_e lo);
    tab_ctrl[idx]     = c;
    tab_src[idx]      = src;
    tab_en_len[idx]   = len;
    tab_init[idx]     = init;
    tab_dds[idx]      = dds;
    tab_dds_rand[idx] = rnd;
    tab_upper[idx]    = up;
    tab_lower[idx]    = lo;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_245_76MHz);
    #1;
    if (row_rand) begin
      dds_iq = $urandom;
    end
  endtask

  task automatic end_test();
    test_end = 1'b1;
    next_cycle();
    test_end = 1'b0;
  endtask

  task automatic wait_for_last(output logic seen);
    int cyc;
    seen = 1'b0;
    cyc  = 0;
    while (!seen && cyc < LAST_TIMEOUT) begin
      @(negedge clk_245_76MHz);
      seen = cap_tlast;
      cyc++;
      if (!seen) begin
        next_cycle();
      end
    end
  endtask

  task automatic run_row(input int idx, output logic timeout);
    logic seen;
    next_cycle();
    test_id   = idx + 1;
    ctrl_word = tab_ctrl[idx];
    dds_iq    = tab_dds[idx];
    row_rand  = tab_dds_rand[idx];
    exp_upper = tab_upper[idx];
    exp_lower = tab_lower[idx];
    // only source bits 11 pick the waveform window
    exp_delay = (tab_src[idx] == 2'b11) ? `DELAY_WFRM : `DELAY_CHIRP;
    // let the adc delay line fill
    repeat (`LOOPBACK_DELAY + 8) next_cycle();
    if (tab_init[idx]) begin
      chirp_init = 1'b1;
      next_cycle();
      chirp_init = 1'b0;
    end
    adc_enable = 1'b1;
    repeat (tab_en_len[idx]) next_cycle();
    adc_enable = 1'b0;
    wait_for_last(seen);
    timeout = !seen;
    if (timeout) begin
      $display("test %0d: timed out waiting for cap_tlast_o", test_id);
    end else begin
      repeat (2) next_cycle();
      end_test();
    end
  endtask

  initial begin
    clk_245_76MHz = 1'b0;
    cpu_reset     = 1'b1;
    dds_iq        = '0;
    ctrl_word     = '0;
    adc_enable    = 1'b0;
    chirp_init    = 1'b0;
    test_end      = 1'b0;
    test_id       = 0;
    exp_upper     = ROUTE_ADC;
    exp_lower     = ROUTE_ADC;
    exp_delay     = `DELAY_CHIRP;
    row_rand      = 1'b0;
    timed_out     = 1'b0;
    seed          = $urandom(17);
    // ctrl, src, enable cycles, init, dds, random dds, upper route, lower route
    set_row(0, 32'h0000_0021, 2'b00, 12, 1'b0, 32'h1234_8765, 1'b1, ROUTE_SAMPLE_CNT, ROUTE_DAC);
    set_row(1, 32'h0000_0330, 2'b11, 10, 1'b0, 32'h8001_7FFE, 1'b0, ROUTE_GLOBAL_CNT, ROUTE_ADC);
    set_row(2, 32'hA5A5_F0BE, 2'b00, 6, 1'b0, 32'h0, 1'b1, ROUTE_GLOBAL_CNT, ROUTE_SAMPLE_CNT);
    set_row(3, 32'h0000_0101, 2'b01, 1, 1'b0, 32'hFFFF_0003, 1'b0, ROUTE_ADC, ROUTE_DAC);
    set_row(4, 32'h0000_0332, 2'b11, 30, 1'b1, 32'h0, 1'b1, ROUTE_GLOBAL_CNT, ROUTE_SAMPLE_CNT);
    set_row(5, 32'h0000_0013, 2'b00, 8, 1'b1, 32'h0, 1'b1, ROUTE_DAC, ROUTE_GLOBAL_CNT);
    set_row(6, 32'hFFFF_FF00, 2'b11, 5, 1'b0, 32'h4000_C001, 1'b0, ROUTE_ADC, ROUTE_ADC);
    repeat (3) next_cycle();
    cpu_reset = 1'b0;
    // test 0, enable held low after reset
    repeat (20) next_cycle();
    end_test();
    for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
      run_row(r, timed_out);
    end
    next_cycle();
    $display("summary: %0d tests passed, %0d failed, %0d timed out",
             pass_cnt, fail_cnt, timed_out);
    if (!timed_out && fail_cnt == 0 && pass_cnt == NUM_ROWS + 1) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/capture_pkg.sv
rtl/ctrl_word_decode.sv
rtl/dac_adc_loopback.sv
capture/capture_sequencer.sv
capture/capture_word_builder.sv
rtl/chirp_capture_top.sv
sim/capture_checker.sv
sim/tb_chirp_capture.sv
